// ==== cpc_bus_pkg.sv ====
////////////////////////////////////////////////////////////
// CPU bus types
// Sampled Z80 bus, Multiface state and mode, capture ops
////////////////////////////////////////////////////////////

`include "cpc_defines.svh"

package cpc_bus_pkg;

	// One clock's view of the CPU bus
	typedef struct packed {
		logic [`CPC_ADDR_W-1:0] addr;
		logic [`CPC_DATA_W-1:0] dout;
		logic                   m1;
		logic                   io_wr;
		logic                   mem_rd;
		logic                   mem_wr;
	} cpu_bus_t;

	typedef enum logic [1:0] {
		MF2_OFF,
		MF2_PENDING,
		MF2_ON
	} mf2_state_e;

	// Same order as the menu option
	typedef enum logic [1:0] {
		MODE_ENABLED,
		MODE_HIDDEN,
		MODE_DISABLED
	} mf2_mode_e;

	// Which hardware register a port write belongs to
	typedef enum logic [3:0] {
		ST_NONE,
		ST_PEN_INDEX,
		ST_PEN_COLOR,
		ST_BORDER,
		ST_SCREEN_MODE,
		ST_BANKING,
		ST_CRTC_SEL,
		ST_CRTC_VAL,
		ST_PPI,
		ST_UPPER_ROM
	} store_op_e;

endpackage

// ==== cpc_defines.svh ====
////////////////////////////////////////////////////////////
// CPC expansion shared constants
// Bus widths, boot bank layout, Multiface ports and RAM map
////////////////////////////////////////////////////////////

`ifndef CPC_DEFINES_SVH
`define CPC_DEFINES_SVH

// Bus and download widths
`define CPC_ADDR_W      16
`define CPC_DATA_W      8
`define CPC_BOOT_A_W    23
`define CPC_DL_ADDR_W   25
`define CPC_PAGE_W      14
`define CPC_ROM_PAGES   256

// System ROM pages inside the 8 MB bank
`define CPC_PAGE_OS     9'h000
`define CPC_PAGE_BASIC  9'h100
`define CPC_PAGE_AMSDOS 9'h107
`define CPC_PAGE_MF2    9'h0FF

// Spare upper page for a malformed extension
`define CPC_PAGE_BAD    8'hEE

// Multiface Two
`define MF2_RAM_A_W     13
`define MF2_RAM_SIZE    8192
`define MF2_PORT_ON     16'hFEE8
`define MF2_PORT_OFF    16'hFEEA
`define MF2_NMI_VEC     16'h0066
`define MF2_HIDE_VEC    16'h0065

// Where captured port writes land in Multiface RAM
`define MF2_CAP_PEN_INDEX 13'h1FCF
`define MF2_CAP_PEN_BASE  13'h1F90
`define MF2_CAP_BORDER    13'h1FDF
`define MF2_CAP_MODE      13'h1FEF
`define MF2_CAP_BANKING   13'h1FFF
`define MF2_CAP_CRTC_SEL  13'h1CFF
`define MF2_CAP_CRTC_BASE 13'h1DB0
`define MF2_CAP_PPI       13'h17FF
`define MF2_CAP_UPPER_ROM 13'h1AAC

`endif

// ==== cpc_expansion_top.sv ====
////////////////////////////////////////////////////////////
// CPC expansion top level
// ROM download loader and Multiface Two interface
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cpc_defines.svh"

module cpc_expansion_top (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Host download
	input  logic                      dl_active,
	input  logic                      dl_req,
	input  cpc_load_pkg::dl_byte_t    dl,
	output logic                      dl_ack,
	output cpc_load_pkg::boot_write_t boot,
	output logic [`CPC_ROM_PAGES-1:0] rom_map,

	// CPU side
	input  cpc_bus_pkg::cpu_bus_t     bus,
	input  logic                      key_nmi,
	input  cpc_bus_pkg::mf2_mode_e    mf2_mode,
	output logic                      mf2_nmi,
	output logic                      mf2_en,
	output logic                      mf2_rom_en,
	output logic                      mf2_ram_en,
	output logic [`CPC_DATA_W-1:0]    mf2_dout
);

	logic                    cap_we;
	logic [`MF2_RAM_A_W-1:0] cap_addr;

	rom_loader u_loader (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_req    (dl_req),
		.dl        (dl),
		.dl_ack    (dl_ack),
		.boot      (boot),
		.rom_map   (rom_map)
	);

	mf2_control u_mf2_ctrl (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.key_nmi  (key_nmi),
		.mode     (mf2_mode),
		.nmi      (mf2_nmi),
		.en       (mf2_en),
		.rom_en   (mf2_rom_en),
		.ram_en   (mf2_ram_en),
		.cap_we   (cap_we),
		.cap_addr (cap_addr)
	);

	mf2_ram u_mf2_ram (
		.clk_sys  (clk_sys),
		.bus      (bus),
		.ram_en   (mf2_ram_en),
		.cap_we   (cap_we),
		.cap_addr (cap_addr),
		.dout     (mf2_dout)
	);

endmodule

// ==== cpc_load_pkg.sv ====
////////////////////////////////////////////////////////////
// ROM download types
// Host download byte, boot write and ROM kind
////////////////////////////////////////////////////////////

`include "cpc_defines.svh"

package cpc_load_pkg;

	// Byte offered by the host, held stable while dl_req is high
	typedef struct packed {
		logic [`CPC_DL_ADDR_W-1:0] addr;
		logic [`CPC_DATA_W-1:0]    data;
		logic [7:0]                index;
		logic [15:0]               ext;
	} dl_byte_t;

	typedef struct packed {
		logic [`CPC_BOOT_A_W-1:0] addr;
		logic [1:0]               bank;
		logic [`CPC_DATA_W-1:0]   data;
		logic                     we;
	} boot_write_t;

	typedef enum logic {
		KIND_SYSTEM,
		KIND_EXPANSION
	} rom_kind_e;

endpackage

// ==== cpc_vectors.txt ====
# DL new index ext addr data nwrites exp_addr exp_bank
# BUS addr dout m1 io_wr mem_rd mem_wr nmi en rom_en ram_en dout, KEY nmi, MODE mode
# System ROM blocks 0 to 7, then a block of 8 that writes nothing
DL 1 00 0000 0000010 a1 1 000010 0
DL 0 00 0000 0004020 a2 1 400020 0
DL 0 00 0000 0008030 a3 1 41c030 0
DL 0 00 0000 000c040 a4 1 3fc040 0
DL 0 00 0000 0010050 a5 1 000050 1
DL 0 00 0000 0014060 a6 1 400060 1
DL 0 00 0000 0018070 a7 1 41c070 1
DL 0 00 0000 001ffff a8 1 3fffff 1
DL 0 00 0000 0020000 a9 0 000000 0
# Expansion ROMs with extensions 1A, ZZ and Q?
DL 1 01 3141 0000005 11 2 468005 0
DL 0 01 3141 0004007 22 2 46c007 0
DL 1 02 5a5a 0000100 33 2 400100 0
DL 1 03 513f 0000200 44 2 7b8200 0
# NMI key ignored when disabled, then taken
MODE 2
KEY 0
MODE 0
KEY 1
BUS 0066 00 1 0 0 0 0 1 1 0 ff
# Gate array, CRTC and upper ROM port writes
BUS 7f00 03 0 1 0 0 0 1 0 0 ff
BUS 7f00 4b 0 1 0 0 0 1 0 0 ff
BUS bc00 0c 0 1 0 0 0 1 0 0 ff
BUS bd00 30 0 1 0 0 0 1 0 0 ff
BUS df00 07 0 1 0 0 0 1 0 0 ff
# Read the captured values back through the overlay
BUS 3fcf 00 0 0 1 0 0 1 0 1 03
BUS 3f93 00 0 0 1 0 0 1 0 1 4b
BUS 3cff 00 0 0 1 0 0 1 0 1 0c
BUS 3dbc 00 0 0 1 0 0 1 0 1 30
BUS 3aac 00 0 0 1 0 0 1 0 1 07
# Port switching and the hide fetch
BUS feea 00 0 1 0 0 0 0 0 0 ff
BUS 3fcf 00 0 0 1 0 0 0 0 0 ff
BUS fee8 00 0 1 0 0 0 1 0 0 ff
BUS 0065 00 1 0 0 0 0 1 1 0 ff
BUS feea 00 0 1 0 0 0 0 0 0 ff
BUS fee8 00 0 1 0 0 0 0 0 0 ff

// ==== mf2_control.sv ====
////////////////////////////////////////////////////////////
// Multiface Two control
// NMI, overlay enable and hide logic, port write capture
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cpc_defines.svh"

module mf2_control (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  cpc_bus_pkg::cpu_bus_t    bus,
	input  logic                     key_nmi,
	input  cpc_bus_pkg::mf2_mode_e   mode,
	output logic                     nmi,
	output logic                     en,
	output logic                     rom_en,
	output logic                     ram_en,
	output logic                     cap_we,
	output logic [`MF2_RAM_A_W-1:0]  cap_addr
);

	cpc_bus_pkg::mf2_state_e state;
	cpc_bus_pkg::store_op_e  store_op;
	logic                    hidden;
	logic                    disabled;
	logic                    m1_q;
	logic                    io_wr_q;
	logic                    key_q;
	logic                    m1_rise;
	logic                    io_wr_rise;
	logic                    key_rise;
	logic [4:0]              pen_index;
	logic [3:0]              crtc_reg;
	logic [`MF2_RAM_A_W-1:0] store_addr;

	assign disabled   = (mode == cpc_bus_pkg::MODE_DISABLED);
	assign m1_rise    = bus.m1 && !m1_q;
	assign io_wr_rise = bus.io_wr && !io_wr_q;
	assign key_rise   = key_nmi && !key_q;

	////////////////////////////////////////////////////////////
	// Port write decoder
	////////////////////////////////////////////////////////////

	always_comb begin
		store_op = cpc_bus_pkg::ST_NONE;
		case (bus.addr[15:8])
			8'h7F: begin
				// Gate array function in the top two data bits
				case (bus.dout[7:6])
					2'b00:   store_op = cpc_bus_pkg::ST_PEN_INDEX;
					2'b01:   store_op = pen_index[4] ? cpc_bus_pkg::ST_BORDER
						: cpc_bus_pkg::ST_PEN_COLOR;
					2'b10:   store_op = cpc_bus_pkg::ST_SCREEN_MODE;
					default: store_op = cpc_bus_pkg::ST_BANKING;
				endcase
			end
			8'hBC:   store_op = cpc_bus_pkg::ST_CRTC_SEL;
			8'hBD:   store_op = cpc_bus_pkg::ST_CRTC_VAL;
			8'hF7:   store_op = cpc_bus_pkg::ST_PPI;
			8'hDF:   store_op = cpc_bus_pkg::ST_UPPER_ROM;
			default: store_op = cpc_bus_pkg::ST_NONE;
		endcase
	end

	always_comb begin
		case (store_op)
			cpc_bus_pkg::ST_PEN_INDEX:   store_addr = `MF2_CAP_PEN_INDEX;
			cpc_bus_pkg::ST_PEN_COLOR:   store_addr = `MF2_CAP_PEN_BASE + {9'd0, pen_index[3:0]};
			cpc_bus_pkg::ST_BORDER:      store_addr = `MF2_CAP_BORDER;
			cpc_bus_pkg::ST_SCREEN_MODE: store_addr = `MF2_CAP_MODE;
			cpc_bus_pkg::ST_BANKING:     store_addr = `MF2_CAP_BANKING;
			cpc_bus_pkg::ST_CRTC_SEL:    store_addr = `MF2_CAP_CRTC_SEL;
			cpc_bus_pkg::ST_CRTC_VAL:    store_addr = `MF2_CAP_CRTC_BASE + {9'd0, crtc_reg};
			cpc_bus_pkg::ST_PPI:         store_addr = `MF2_CAP_PPI;
			cpc_bus_pkg::ST_UPPER_ROM:   store_addr = `MF2_CAP_UPPER_ROM;
			default:                     store_addr = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// NMI, enable and hide state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= cpc_bus_pkg::MF2_OFF;
			hidden  <= (mode != cpc_bus_pkg::MODE_ENABLED);
			m1_q    <= 1'b0;
			io_wr_q <= 1'b0;
			key_q   <= 1'b0;
			cap_we  <= 1'b0;
		end else begin
			m1_q    <= bus.m1;
			io_wr_q <= bus.io_wr;
			key_q   <= key_nmi;
			cap_we  <= 1'b0;

			if (key_rise && state == cpc_bus_pkg::MF2_OFF && !disabled)
				state <= cpc_bus_pkg::MF2_PENDING;

			// CPU takes the NMI, overlay pages in
			if (m1_rise && state == cpc_bus_pkg::MF2_PENDING && bus.addr == `MF2_NMI_VEC) begin
				state  <= cpc_bus_pkg::MF2_ON;
				hidden <= 1'b0;
			end
			if (m1_rise && state == cpc_bus_pkg::MF2_ON && bus.addr == `MF2_HIDE_VEC)
				hidden <= 1'b1;

			if (io_wr_rise) begin
				if (bus.addr == `MF2_PORT_ON) begin
					if (!hidden && !disabled)
						state <= cpc_bus_pkg::MF2_ON;
				end else if (bus.addr == `MF2_PORT_OFF) begin
					state <= cpc_bus_pkg::MF2_OFF;
				end else if (store_op != cpc_bus_pkg::ST_NONE) begin
					cap_we <= 1'b1;
				end
			end
		end
	end

	// Shadow copies of write-only registers
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			cap_addr <= store_addr;
			if (store_op == cpc_bus_pkg::ST_PEN_INDEX)
				pen_index <= bus.dout[4:0];
			if (store_op == cpc_bus_pkg::ST_CRTC_SEL)
				crtc_reg <= bus.dout[3:0];
		end
	end

	assign nmi    = (state == cpc_bus_pkg::MF2_PENDING);
	assign en     = (state == cpc_bus_pkg::MF2_ON);
	assign rom_en = en && (bus.addr[15:13] == 3'b000);
	assign ram_en = en && (bus.addr[15:13] == 3'b001);

endmodule

// ==== mf2_ram.sv ====
////////////////////////////////////////////////////////////
// Multiface Two RAM
// 8 KB store for captured registers and CPU accesses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cpc_defines.svh"

module mf2_ram (
	input  logic                    clk_sys,
	input  cpc_bus_pkg::cpu_bus_t   bus,
	input  logic                    ram_en,
	input  logic                    cap_we,
	input  logic [`MF2_RAM_A_W-1:0] cap_addr,
	output logic [`CPC_DATA_W-1:0]  dout
);

	logic [`CPC_DATA_W-1:0]  mem [`MF2_RAM_SIZE];
	logic [`MF2_RAM_A_W-1:0] ram_addr;
	logic                    ram_we;
	logic [`CPC_DATA_W-1:0]  rd_data;
	logic                    rd_valid;

	// Capture wins over a CPU write in the same cycle
	assign ram_we   = cap_we || (bus.mem_wr && ram_en);
	assign ram_addr = cap_we ? cap_addr : bus.addr[`MF2_RAM_A_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= bus.dout;
			rd_data       <= bus.dout;
		end else begin
			rd_data <= mem[ram_addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_valid <= bus.mem_rd && ram_en;
	end

	// Open bus reads as FF
	assign dout = rd_valid ? rd_data : 8'hFF;

endmodule

// ==== rom_loader.sv ====
////////////////////////////////////////////////////////////
// ROM download loader
// Maps host bytes to boot writes and tracks loaded pages
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cpc_defines.svh"

module rom_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_active,
	input  logic                      dl_req,
	input  cpc_load_pkg::dl_byte_t    dl,
	output logic                      dl_ack,
	output cpc_load_pkg::boot_write_t boot,
	output logic [`CPC_ROM_PAGES-1:0] rom_map
);

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WRITE,
		LD_ACK
	} load_state_e;

	load_state_e             state;
	cpc_load_pkg::rom_kind_e kind;
	logic                    dl_active_q;
	logic [7:0]              ext_page;

	logic                     boot_we;
	logic [`CPC_BOOT_A_W-1:0] boot_addr;
	logic [1:0]               boot_bank;
	logic [`CPC_DATA_W-1:0]   boot_data;

	logic [`CPC_DL_ADDR_W-`CPC_PAGE_W-1:0] dl_block;
	logic                     sys_valid;
	logic [8:0]               sys_page;
	logic [`CPC_BOOT_A_W-1:0] map_addr;
	logic [1:0]               map_bank;
	logic                     second_bank;

	// One hex character to {valid, nibble}
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			return {1'b1, c[3:0] + 4'd9};
		else
			return 5'd0;
	endfunction

	function automatic logic [7:0] decode_ext(input logic [15:0] ext);
		logic [4:0] hi;
		logic [4:0] lo;
		hi = hex_nibble(ext[15:8]);
		lo = hex_nibble(ext[7:0]);
		if (ext == "ZZ")
			return 8'h00;
		else if (hi[4] && lo[4])
			return {hi[3:0], lo[3:0]};
		else
			return `CPC_PAGE_BAD;
	endfunction

	////////////////////////////////////////////////////////////
	// Address mapping of the held byte
	////////////////////////////////////////////////////////////

	assign kind      = (dl.index == 8'd0) ? cpc_load_pkg::KIND_SYSTEM : cpc_load_pkg::KIND_EXPANSION;
	assign dl_block  = dl.addr[`CPC_DL_ADDR_W-1:`CPC_PAGE_W];
	assign sys_valid = (dl_block < 8);

	always_comb begin
		case (dl_block[1:0])
			2'd0:    sys_page = `CPC_PAGE_OS;
			2'd1:    sys_page = `CPC_PAGE_BASIC;
			2'd2:    sys_page = `CPC_PAGE_AMSDOS;
			default: sys_page = `CPC_PAGE_MF2;
		endcase

		if (kind == cpc_load_pkg::KIND_EXPANSION) begin
			// Upper ROMs live in the second 4 MB
			map_addr = {1'b1, ext_page + dl.addr[`CPC_PAGE_W+7:`CPC_PAGE_W],
				dl.addr[`CPC_PAGE_W-1:0]};
			map_bank = 2'd0;
		end else begin
			map_addr = {sys_page, dl.addr[`CPC_PAGE_W-1:0]};
			map_bank = {1'b0, dl_block[2]};
		end
	end

	assign second_bank = (kind == cpc_load_pkg::KIND_EXPANSION) && (boot_bank == 2'd0);

	// Page from the extension, latched as a download starts
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			ext_page    <= 8'h00;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active && !dl_active_q)
				ext_page <= decode_ext(dl.ext);
		end
	end

	////////////////////////////////////////////////////////////
	// Handshake and write sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= LD_IDLE;
			boot_we <= 1'b0;
			dl_ack  <= 1'b0;
			rom_map <= '0;
		end else begin
			case (state)
				LD_IDLE: begin
					if (dl_req) begin
						// Out of range system blocks only get acknowledged
						boot_we <= (kind == cpc_load_pkg::KIND_EXPANSION) || sys_valid;
						state   <= LD_WRITE;
					end
				end
				LD_WRITE: begin
					if (second_bank) begin
						rom_map[boot_addr[`CPC_PAGE_W+7:`CPC_PAGE_W]] <= 1'b1;
					end else begin
						boot_we <= 1'b0;
						dl_ack  <= 1'b1;
						state   <= LD_ACK;
					end
				end
				default: begin
					if (!dl_req) begin
						dl_ack <= 1'b0;
						state  <= LD_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == LD_IDLE && dl_req) begin
			boot_addr <= map_addr;
			boot_bank <= map_bank;
			boot_data <= dl.data;
		end else if (state == LD_WRITE && second_bank) begin
			boot_bank <= 2'd1;
		end
	end

	assign boot = '{addr: boot_addr, bank: boot_bank, data: boot_data, we: boot_we};

endmodule

// ==== tb_cpc_expansion.sv ====
////////////////////////////////////////////////////////////
// CPC expansion testbench
// Replays download and CPU bus vectors, checks the DUT
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cpc_defines.svh"

module tb_cpc_expansion;

	localparam int ACK_TIMEOUT = 64;

	logic                      clk_sys;
	logic                      reset;
	logic                      dl_active;
	logic                      dl_req;
	cpc_load_pkg::dl_byte_t    dl;
	logic                      dl_ack;
	cpc_load_pkg::boot_write_t boot;
	logic [`CPC_ROM_PAGES-1:0] rom_map;
	cpc_bus_pkg::cpu_bus_t     bus;
	logic                      key_nmi;
	cpc_bus_pkg::mf2_mode_e    mf2_mode;
	logic                      mf2_nmi;
	logic                      mf2_en;
	logic                      mf2_rom_en;
	logic                      mf2_ram_en;
	logic [`CPC_DATA_W-1:0]    mf2_dout;

	cpc_load_pkg::boot_write_t writes[$];
	integer                    fd;
	integer                    fields;
	logic [8*8-1:0]            op;
	logic [8*200-1:0]          text;
	logic [31:0]               v [0:10];

	cpc_expansion_top UUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_req     (dl_req),
		.dl         (dl),
		.dl_ack     (dl_ack),
		.boot       (boot),
		.rom_map    (rom_map),
		.bus        (bus),
		.key_nmi    (key_nmi),
		.mf2_mode   (mf2_mode),
		.mf2_nmi    (mf2_nmi),
		.mf2_en     (mf2_en),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.mf2_dout   (mf2_dout)
	);

	always #20 clk_sys = ~clk_sys;

	// Boot writes in issue order, boot is registered so stable here
	always @(negedge clk_sys) begin
		if (!reset && boot.we)
			writes.push_back(boot);
	end

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAIL at time %0t: %s is %0h, expected %0h", $time, what, actual,
				expected);
			stop_run();
		end
	endtask

	task automatic wait_ack(input logic level);
		int count;
		count = 0;
		while (dl_ack !== level && count < ACK_TIMEOUT) begin
			@(negedge clk_sys);
			count++;
		end
		if (dl_ack !== level) begin
			if (level)
				$display("Timeout: dl_ack never rose after dl_req was raised");
			else
				$display("Timeout: dl_ack never fell after dl_req was dropped");
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Operations from the vector file
	////////////////////////////////////////////////////////////

	task automatic download_byte(input logic new_dl, input logic [7:0] index,
		input logic [15:0] ext, input logic [24:0] addr, input logic [7:0] data,
		input int nwr, input logic [22:0] exp_addr, input logic [1:0] exp_bank);
		cpc_load_pkg::boot_write_t wr;
		int i;
		dl.index = index;
		dl.ext   = ext;
		dl.addr  = addr;
		dl.data  = data;
		if (new_dl) begin
			// New download, extension is latched on the dl_active edge
			dl_active = 1'b0;
			@(negedge clk_sys);
			dl_active = 1'b1;
			@(negedge clk_sys);
		end
		dl_req = 1'b1;
		wait_ack(1'b1);
		dl_req = 1'b0;
		wait_ack(1'b0);
		check_value(writes.size(), nwr, "boot write count");
		for (i = 0; i < nwr; i++) begin
			wr = writes.pop_front();
			check_value(wr.addr, exp_addr, "boot.addr");
			// Expansion bytes go to bank 0 then bank 1
			check_value(wr.bank, exp_bank + i, "boot.bank");
			check_value(wr.data, data, "boot.data");
		end
		if (nwr == 2)
			check_value(rom_map[exp_addr[`CPC_PAGE_W+7:`CPC_PAGE_W]], 1'b1, "rom_map bit");
	endtask

	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic m1, input logic io_wr, input logic mem_rd, input logic mem_wr,
		input logic exp_nmi, input logic exp_en, input logic exp_rom_en,
		input logic exp_ram_en, input logic [7:0] exp_dout);
		bus.addr   = addr;
		bus.dout   = data;
		bus.m1     = m1;
		bus.io_wr  = io_wr;
		bus.mem_rd = mem_rd;
		bus.mem_wr = mem_wr;
		@(negedge clk_sys);
		check_value(mf2_nmi, exp_nmi, "mf2_nmi");
		check_value(mf2_en, exp_en, "mf2_en");
		check_value(mf2_rom_en, exp_rom_en, "mf2_rom_en");
		check_value(mf2_ram_en, exp_ram_en, "mf2_ram_en");
		check_value(mf2_dout, exp_dout, "mf2_dout");
		// Address and data stay for the capture write one cycle later
		bus.m1     = 1'b0;
		bus.io_wr  = 1'b0;
		bus.mem_rd = 1'b0;
		bus.mem_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic key_press(input logic exp_nmi);
		key_nmi = 1'b1;
		@(negedge clk_sys);
		check_value(mf2_nmi, exp_nmi, "mf2_nmi after key edge");
		key_nmi = 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_req    = 1'b0;
		dl        = '0;
		bus       = '0;
		key_nmi   = 1'b0;
		mf2_mode  = cpc_bus_pkg::MODE_ENABLED;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		check_value(boot.we, 1'b0, "boot.we after reset");
		check_value(dl_ack, 1'b0, "dl_ack after reset");
		check_value(|rom_map, 1'b0, "rom_map after reset");
		check_value(mf2_nmi, 1'b0, "mf2_nmi after reset");
		check_value(mf2_en, 1'b0, "mf2_en after reset");
		check_value(mf2_rom_en, 1'b0, "mf2_rom_en after reset");
		check_value(mf2_ram_en, 1'b0, "mf2_ram_en after reset");

		fd = $fopen("cpc_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file cpc_vectors.txt");
			stop_run();
		end
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				fields = $fgets(text, fd);
			end else if (op == "DL") begin
				fields = $fscanf(fd, "%h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
				if (fields != 8) begin
					$display("Malformed DL line in the vector file");
					stop_run();
				end
				download_byte(v[0][0], v[1][7:0], v[2][15:0], v[3][24:0], v[4][7:0],
					v[5], v[6][22:0], v[7][1:0]);
			end else if (op == "BUS") begin
				fields = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
				if (fields != 11) begin
					$display("Malformed BUS line in the vector file");
					stop_run();
				end
				bus_cycle(v[0][15:0], v[1][7:0], v[2][0], v[3][0], v[4][0], v[5][0],
					v[6][0], v[7][0], v[8][0], v[9][0], v[10][7:0]);
			end else if (op == "KEY") begin
				fields = $fscanf(fd, "%h", v[0]);
				if (fields != 1) begin
					$display("Malformed KEY line in the vector file");
					stop_run();
				end
				key_press(v[0][0]);
			end else if (op == "MODE") begin
				fields = $fscanf(fd, "%h", v[0]);
				if (fields != 1) begin
					$display("Malformed MODE line in the vector file");
					stop_run();
				end
				mf2_mode = cpc_bus_pkg::mf2_mode_e'(v[0][1:0]);
				@(negedge clk_sys);
			end else begin
				$display("Unknown operation %0s in the vector file", op);
				stop_run();
			end
		end
		$fclose(fd);

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
cpc_bus_pkg.sv
cpc_load_pkg.sv
rom_loader.sv
mf2_control.sv
mf2_ram.sv
cpc_expansion_top.sv
tb_cpc_expansion.sv
